//--- design/meter_pkg.sv
/*
 * Memory bus meter subsystem package
 * Shared widths, sizes, bus and APB structs, arbiter states
 * and the word offsets of the meter registers
 */

`default_nettype none

package meter_pkg;

	// Memory bus geometry
	localparam int ADR_W = 10;
	localparam int DATA_W = 32;
	localparam int MEM_DEPTH = 1024;

	// Trace memory geometry
	localparam int CAP_DEPTH = 64;
	// Extra top bit flags a stopped capture
	localparam int CAP_PTR_W = 7;

	// Meter register word offsets
	localparam logic [2:0] REG_CTRL = 3'd0;
	localparam logic [2:0] REG_STB_COUNT = 3'd1;
	localparam logic [2:0] REG_ACK_COUNT = 3'd2;
	localparam logic [2:0] REG_CAP_WPTR = 3'd3;
	localparam logic [2:0] REG_CAP_RPTR = 3'd4;
	localparam logic [2:0] REG_CAP_DATA = 3'd5;

	typedef logic [ADR_W-1:0] bus_adr_t;
	typedef logic [DATA_W-1:0] bus_data_t;
	typedef logic [31:0] count_t;
	typedef logic [CAP_PTR_W-1:0] cap_ptr_t;
	typedef logic [CAP_PTR_W-2:0] cap_idx_t;
	typedef logic [4:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Master to memory request
	typedef struct packed {
		logic stb;
		logic we;
		bus_adr_t adr;
		bus_data_t dat_w;
	} fml_req_t;

	// Memory to master response
	typedef struct packed {
		logic ack;
		bus_data_t dat_r;
	} fml_rsp_t;

	// APB request, no wait states, no error response
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		logic pready;
		apb_data_t prdata;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_M0,
		ARB_M1
	} arb_state_t;

endpackage

`default_nettype wire

//--- design/fml_arbiter.sv
/*
 * Two-master round-robin arbiter
 * Grants the shared memory link from strobe until acknowledge
 * and routes the response to the granted master only
 */

`timescale 1ns/1ps
`default_nettype none

module fml_arbiter (
	input  wire logic                sys_clk,
	input  wire logic                sys_rst,
	input  wire meter_pkg::fml_req_t m0_req,
	input  wire meter_pkg::fml_req_t m1_req,
	output meter_pkg::fml_rsp_t      m0_rsp,
	output meter_pkg::fml_rsp_t      m1_rsp,
	output meter_pkg::fml_req_t      mem_req,
	input  wire meter_pkg::fml_rsp_t mem_rsp
);

	meter_pkg::arb_state_t state_q;
	meter_pkg::arb_state_t state_d;
	// Set when master 1 was served last
	logic last_m1_q;
	// Choice made while idle
	logic pick_m1;
	logic grant_m0;
	logic grant_m1;

	// Round-robin pick, only matters on a tie
	always_comb begin
		if (m0_req.stb && m1_req.stb)
			pick_m1 = ~last_m1_q;
		else
			pick_m1 = m1_req.stb;
	end

	// Grant is live in the strobe cycle, then held by state
	always_comb begin
		grant_m0 = 1'b0;
		grant_m1 = 1'b0;
		case (state_q)
			meter_pkg::ARB_M0: grant_m0 = 1'b1;
			meter_pkg::ARB_M1: grant_m1 = 1'b1;
			default: begin
				grant_m1 = pick_m1;
				grant_m0 = m0_req.stb & ~pick_m1;
			end
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			meter_pkg::ARB_IDLE: begin
				if (grant_m1)
					state_d = meter_pkg::ARB_M1;
				else if (grant_m0)
					state_d = meter_pkg::ARB_M0;
			end
			// Release on the acknowledge cycle
			default: if (mem_rsp.ack) state_d = meter_pkg::ARB_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= meter_pkg::ARB_IDLE;
			last_m1_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (mem_rsp.ack)
				last_m1_q <= grant_m1;
		end
	end

	// Request mux, strobe only when someone holds the grant
	always_comb begin
		mem_req = grant_m1 ? m1_req : m0_req;
		mem_req.stb = (grant_m0 & m0_req.stb) | (grant_m1 & m1_req.stb);
	end

	// Read data fans out, ack only to the owner
	always_comb begin
		m0_rsp.dat_r = mem_rsp.dat_r;
		m1_rsp.dat_r = mem_rsp.dat_r;
		m0_rsp.ack = mem_rsp.ack & grant_m0;
		m1_rsp.ack = mem_rsp.ack & grant_m1;
	end

endmodule

`default_nettype wire

//--- design/fml_sram.sv
/*
 * Single-port 1024x32 SRAM on the memory bus
 * Registered read, acknowledge one cycle after strobe
 */

`timescale 1ns/1ps
`default_nettype none

module fml_sram (
	input  wire logic                sys_clk,
	input  wire logic                sys_rst,
	input  wire meter_pkg::fml_req_t mem_req,
	output meter_pkg::fml_rsp_t      mem_rsp
);

	meter_pkg::bus_data_t mem [meter_pkg::MEM_DEPTH];
	meter_pkg::bus_data_t rd_q;
	logic ack_q;

	// One ack per strobe, then low for a cycle
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			ack_q <= 1'b0;
		else
			ack_q <= mem_req.stb & ~ack_q;
	end

	// Write commits at the end of the ack cycle
	always_ff @(posedge sys_clk) begin
		if (mem_req.stb && ack_q && mem_req.we)
			mem[mem_req.adr] <= mem_req.dat_w;
	end

	// Read word sampled in the first strobe cycle
	always_ff @(posedge sys_clk) begin
		rd_q <= mem[mem_req.adr];
	end

	always_comb begin
		mem_rsp.ack = ack_q;
		mem_rsp.dat_r = rd_q;
	end

endmodule

`default_nettype wire

//--- design/bus_meter.sv
/*
 * Memory bus meter
 * Counts strobe and ack cycles, traces completed transfer
 * addresses into a 64-entry memory, APB register access
 */

`timescale 1ns/1ps
`default_nettype none

module bus_meter (
	input  wire logic                sys_clk,
	input  wire logic                sys_rst,
	input  wire meter_pkg::fml_req_t probe_req,
	input  wire meter_pkg::fml_rsp_t probe_rsp,
	input  wire meter_pkg::apb_req_t apb_req,
	output meter_pkg::apb_rsp_t      apb_rsp
);

	// Probe stage
	logic stb_r;
	logic ack_r;
	meter_pkg::bus_adr_t adr_r;

	// Register state
	logic counters_en;
	meter_pkg::count_t stb_count;
	meter_pkg::count_t ack_count;
	meter_pkg::cap_ptr_t cap_wptr;
	meter_pkg::cap_idx_t cap_rptr;
	meter_pkg::bus_adr_t cap_data;

	// Trace memory, separate read port
	meter_pkg::bus_adr_t cap_mem [meter_pkg::CAP_DEPTH];
	logic cap_we;

	// APB decode
	logic [2:0] reg_off;
	logic apb_wr;
	logic apb_setup;
	meter_pkg::apb_data_t rd_mux;
	meter_pkg::apb_data_t prdata_q;

	// Probed bus seen one cycle late
	always_ff @(posedge sys_clk) begin
		stb_r <= probe_req.stb;
		ack_r <= probe_rsp.ack;
		adr_r <= probe_req.adr;
	end

	// Capture runs while the stop bit is clear
	assign cap_we = ~cap_wptr[meter_pkg::CAP_PTR_W-1] & stb_r & ack_r;

	always_ff @(posedge sys_clk) begin
		if (cap_we)
			cap_mem[cap_wptr[meter_pkg::CAP_PTR_W-2:0]] <= adr_r;
		cap_data <= cap_mem[cap_rptr];
	end

	assign reg_off = apb_req.paddr[4:2];
	// Writes land in the access cycle
	assign apb_wr = apb_req.psel & apb_req.penable & apb_req.pwrite;
	// Read data is fetched in the setup cycle
	assign apb_setup = apb_req.psel & ~apb_req.penable;

	always_comb begin
		case (reg_off)
			meter_pkg::REG_CTRL: rd_mux = {31'd0, counters_en};
			meter_pkg::REG_STB_COUNT: rd_mux = stb_count;
			meter_pkg::REG_ACK_COUNT: rd_mux = ack_count;
			meter_pkg::REG_CAP_WPTR: rd_mux = {25'd0, cap_wptr};
			meter_pkg::REG_CAP_RPTR: rd_mux = {26'd0, cap_rptr};
			meter_pkg::REG_CAP_DATA: rd_mux = {22'd0, cap_data};
			// Unmapped offsets
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			counters_en <= 1'b0;
			stb_count <= '0;
			ack_count <= '0;
			// Stopped until software arms it
			cap_wptr <= meter_pkg::cap_ptr_t'(meter_pkg::CAP_DEPTH);
			cap_rptr <= '0;
			prdata_q <= '0;
		end else begin
			if (counters_en) begin
				if (stb_r)
					stb_count <= stb_count + 32'd1;
				if (ack_r)
					ack_count <= ack_count + 32'd1;
			end

			if (cap_we)
				cap_wptr <= cap_wptr + 7'd1;

			// Software writes override bus events
			if (apb_wr) begin
				case (reg_off)
					meter_pkg::REG_CTRL: begin
						counters_en <= apb_req.pwdata[0];
						// Enabling starts from zero
						if (apb_req.pwdata[0]) begin
							stb_count <= '0;
							ack_count <= '0;
						end
					end
					// Re-arm capture
					meter_pkg::REG_CAP_WPTR: cap_wptr <= '0;
					meter_pkg::REG_CAP_RPTR:
						cap_rptr <= apb_req.pwdata[meter_pkg::CAP_PTR_W-2:0];
					// Counts and trace data are read-only
					default: ;
				endcase
			end

			// Zero outside access cycles
			prdata_q <= '0;
			if (apb_setup && !apb_req.pwrite)
				prdata_q <= rd_mux;
		end
	end

	always_comb begin
		apb_rsp.pready = apb_req.psel & apb_req.penable;
		apb_rsp.prdata = prdata_q;
	end

endmodule

`default_nettype wire

//--- design/meter_subsystem_top.sv
/*
 * Memory bus observer subsystem top
 * Two masters share one SRAM through the arbiter, the meter
 * snoops the arbitrated link and answers on APB
 */

`timescale 1ns/1ps
`default_nettype none

module meter_subsystem_top (
	input  wire logic                sys_clk,
	input  wire logic                sys_rst,
	input  wire meter_pkg::fml_req_t m0_req,
	output meter_pkg::fml_rsp_t      m0_rsp,
	input  wire meter_pkg::fml_req_t m1_req,
	output meter_pkg::fml_rsp_t      m1_rsp,
	input  wire meter_pkg::apb_req_t apb_req,
	output meter_pkg::apb_rsp_t      apb_rsp
);

	// Arbitrated link between arbiter and SRAM
	meter_pkg::fml_req_t arb_req;
	meter_pkg::fml_rsp_t arb_rsp;

	fml_arbiter u_arbiter (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.m0_req  (m0_req),
		.m1_req  (m1_req),
		.m0_rsp  (m0_rsp),
		.m1_rsp  (m1_rsp),
		.mem_req (arb_req),
		.mem_rsp (arb_rsp)
	);

	fml_sram u_sram (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.mem_req (arb_req),
		.mem_rsp (arb_rsp)
	);

	// Meter only listens on the link
	bus_meter u_meter (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.probe_req (arb_req),
		.probe_rsp (arb_rsp),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp)
	);

endmodule

`default_nettype wire

//--- verification/meter_props.sv
/*
 * Arbiter and memory handshake assertions
 * One ack owner, held requests, no back-to-back ack
 */

`timescale 1ns/1ps
`default_nettype none

module meter_props (
	input wire logic                sys_clk,
	input wire logic                sys_rst,
	input wire meter_pkg::fml_rsp_t m0_rsp,
	input wire meter_pkg::fml_rsp_t m1_rsp,
	input wire meter_pkg::fml_req_t mem_req,
	input wire meter_pkg::fml_rsp_t mem_rsp
);

	// Every memory ack reaches exactly one master
	a_single_ack: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_rsp.ack |-> (m0_rsp.ack ^ m1_rsp.ack))
		else $error("memory ack not routed to exactly one master");

	// Request frozen while waiting for ack
	a_req_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(mem_req.stb && !mem_rsp.ack) |=> $stable(mem_req))
		else $error("memory request changed before ack");

	// Ack lands on a held strobe, then drops for a cycle
	a_ack_gap: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_rsp.ack |=> (!mem_rsp.ack && $past(mem_req.stb)))
		else $error("ack without strobe or high in two consecutive cycles");

endmodule

bind fml_arbiter meter_props u_props (
	.sys_clk (sys_clk),
	.sys_rst (sys_rst),
	.m0_rsp  (m0_rsp),
	.m1_rsp  (m1_rsp),
	.mem_req (mem_req),
	.mem_rsp (mem_rsp)
);

`default_nettype wire

//--- verification/tb_meter_subsystem.sv
/*
 * Testbench for the memory bus observer subsystem
 * Random traffic from both masters against a memory model,
 * meter counts and address trace read back over APB
 */

`timescale 1ns/1ps
`default_nettype none

module tb_meter_subsystem;

	localparam int CLK_PERIOD = 40;
	// Transfers per master in each phase
	localparam int N_COUNT = 15;
	localparam int N_WRAP = 20;
	localparam int N_HOLD = 4;
	localparam int N_REARM = 10;
	localparam int TOTAL_XFERS = 2 * (N_COUNT + N_WRAP + N_HOLD + N_REARM);
	// Margin covers APB accesses and trace readback
	localparam int WATCHDOG_CYCLES = TOTAL_XFERS * 20 + 2000;

	logic sys_clk = 1'b0;
	logic sys_rst;
	meter_pkg::fml_req_t m0_req;
	meter_pkg::fml_req_t m1_req;
	meter_pkg::fml_rsp_t m0_rsp;
	meter_pkg::fml_rsp_t m1_rsp;
	meter_pkg::apb_req_t apb_req;
	meter_pkg::apb_rsp_t apb_rsp;

	integer seed = 37940;

	// Traffic drawn ahead of each phase
	meter_pkg::fml_req_t traffic [2][32];
	bit idle_gap [2][32];

	// Reference model
	meter_pkg::bus_data_t model_mem [meter_pkg::MEM_DEPTH];
	bit model_ok [meter_pkg::MEM_DEPTH];
	meter_pkg::bus_adr_t trace_q [$];
	bit capture_armed = 1'b0;
	bit count_en = 1'b0;
	meter_pkg::count_t exp_stb = '0;
	meter_pkg::count_t exp_ack = '0;

	meter_subsystem_top u_meter_subsystem_top (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.m0_req  (m0_req),
		.m0_rsp  (m0_rsp),
		.m1_req  (m1_req),
		.m1_rsp  (m1_rsp),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout: a transfer or register access never completed");
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
		$display("Simulation FAILED");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "%s", what);
	endtask

	task automatic check_data(input string name, input meter_pkg::bus_data_t exp,
			input meter_pkg::bus_data_t act);
		if (act !== exp)
			report_mismatch(name, exp, act);
	endtask

	task automatic check_count(input string name, input meter_pkg::count_t exp,
			input meter_pkg::count_t act);
		if (act !== exp)
			report_mismatch(name, exp, act);
	endtask

	task automatic check_ptr(input string name, input meter_pkg::cap_ptr_t exp,
			input meter_pkg::cap_ptr_t act);
		if (act !== exp)
			report_mismatch(name, 32'(exp), 32'(act));
	endtask

	task automatic check_trace(input string name, input meter_pkg::bus_adr_t exp,
			input meter_pkg::bus_adr_t act);
		if (act !== exp)
			report_mismatch(name, 32'(exp), 32'(act));
	endtask

	// No ready and no read data before the access cycle
	task automatic expect_quiet_setup();
		@(negedge sys_clk);
		if (apb_rsp.pready !== 1'b0)
			report_failure("APB pready was high during a setup cycle");
		check_data("apb_rsp.prdata", '0, apb_rsp.prdata);
	endtask

	// Setup cycle, access cycle, then one idle cycle
	task automatic apb_write(input logic [2:0] off, input meter_pkg::apb_data_t data);
		@(posedge sys_clk);
		#2;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b1;
		apb_req.paddr = {off, 2'b00};
		apb_req.pwdata = data;
		expect_quiet_setup();
		@(posedge sys_clk);
		#2;
		apb_req.penable = 1'b1;
		@(negedge sys_clk);
		while (!apb_rsp.pready)
			@(negedge sys_clk);
		@(posedge sys_clk);
		#2;
		apb_req = '0;
	endtask

	task automatic apb_read(input logic [2:0] off, output meter_pkg::apb_data_t data);
		@(posedge sys_clk);
		#2;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
		apb_req.paddr = {off, 2'b00};
		apb_req.pwdata = '0;
		expect_quiet_setup();
		@(posedge sys_clk);
		#2;
		apb_req.penable = 1'b1;
		// prdata valid mid access cycle
		@(negedge sys_clk);
		while (!apb_rsp.pready)
			@(negedge sys_clk);
		data = apb_rsp.prdata;
		@(posedge sys_clk);
		#2;
		apb_req = '0;
	endtask

	task automatic gen_traffic(input int n);
		logic [31:0] rnd;
		meter_pkg::bus_adr_t base;
		int idx;
		int k;
		rnd = $random(seed);
		base = rnd[9:0];
		for (idx = 0; idx < 2; idx++) begin
			for (k = 0; k < n; k++) begin
				rnd = $random(seed);
				traffic[idx][k].stb = 1'b1;
				traffic[idx][k].we = rnd[31];
				// Small window so reads often hit written words
				traffic[idx][k].adr = base + meter_pkg::bus_adr_t'(rnd[4:0]);
				traffic[idx][k].dat_w = $random(seed);
				idle_gap[idx][k] = (rnd[9:8] == 2'b00);
			end
		end
	endtask

	task automatic drive_master(input int idx, input meter_pkg::fml_req_t r);
		if (idx == 0)
			m0_req = r;
		else
			m1_req = r;
	endtask

	// Model update at ack, one ack per cycle keeps the order
	task automatic retire_transfer(input int idx, input meter_pkg::fml_req_t r,
			input meter_pkg::fml_rsp_t rsp);
		if (r.we) begin
			model_mem[r.adr] = r.dat_w;
			model_ok[r.adr] = 1'b1;
		end else if (model_ok[r.adr]) begin
			check_data(idx == 0 ? "m0_rsp.dat_r" : "m1_rsp.dat_r",
				model_mem[r.adr], rsp.dat_r);
		end
		// Two strobe cycles and one ack per transfer
		if (count_en) begin
			exp_stb = exp_stb + 32'd2;
			exp_ack = exp_ack + 32'd1;
		end
		if (capture_armed && trace_q.size() < meter_pkg::CAP_DEPTH)
			trace_q.push_back(r.adr);
	endtask

	task automatic run_master(input int idx, input int n);
		meter_pkg::fml_rsp_t rsp;
		int k;
		for (k = 0; k < n; k++) begin
			@(posedge sys_clk);
			#2;
			drive_master(idx, traffic[idx][k]);
			// Hold until this master sees ack
			rsp = '0;
			while (!rsp.ack) begin
				@(negedge sys_clk);
				rsp = (idx == 0) ? m0_rsp : m1_rsp;
			end
			retire_transfer(idx, traffic[idx][k], rsp);
			if (idle_gap[idx][k]) begin
				@(posedge sys_clk);
				#2;
				drive_master(idx, '0);
			end
		end
		@(posedge sys_clk);
		#2;
		drive_master(idx, '0);
	endtask

	task automatic run_traffic(input int n);
		gen_traffic(n);
		fork
			run_master(0, n);
			run_master(1, n);
		join
		// Probe stage and counters settle
		repeat (4) @(posedge sys_clk);
	endtask

	function automatic meter_pkg::cap_ptr_t expected_wptr();
		if (!capture_armed)
			return meter_pkg::cap_ptr_t'(meter_pkg::CAP_DEPTH);
		return meter_pkg::cap_ptr_t'(trace_q.size());
	endfunction

	task automatic verify_counts();
		meter_pkg::apb_data_t d;
		apb_read(meter_pkg::REG_STB_COUNT, d);
		check_count("stb_count", exp_stb, d);
		apb_read(meter_pkg::REG_ACK_COUNT, d);
		check_count("ack_count", exp_ack, d);
	endtask

	task automatic check_wptr();
		meter_pkg::apb_data_t d;
		apb_read(meter_pkg::REG_CAP_WPTR, d);
		check_ptr("cap_wptr", expected_wptr(), meter_pkg::cap_ptr_t'(d));
	endtask

	// Pointer write, idle cycle, then data read
	task automatic verify_trace();
		meter_pkg::apb_data_t d;
		int i;
		check_wptr();
		for (i = 0; i < trace_q.size(); i++) begin
			apb_write(meter_pkg::REG_CAP_RPTR, meter_pkg::apb_data_t'(i));
			apb_read(meter_pkg::REG_CAP_DATA, d);
			check_trace("cap_data", trace_q[i], meter_pkg::bus_adr_t'(d));
		end
	endtask

	task automatic arm_capture();
		apb_write(meter_pkg::REG_CAP_WPTR, '0);
		capture_armed = 1'b1;
		trace_q.delete();
	endtask

	initial begin
		meter_pkg::apb_data_t d;
		sys_rst = 1'b1;
		m0_req = '0;
		m1_req = '0;
		apb_req = '0;
		repeat (5) @(posedge sys_clk);
		#2;
		sys_rst = 1'b0;

		// Register state after reset
		apb_read(meter_pkg::REG_CTRL, d);
		check_data("ctrl", '0, d);
		verify_counts();
		check_wptr();
		apb_read(meter_pkg::REG_CAP_RPTR, d);
		check_ptr("cap_rptr", '0, meter_pkg::cap_ptr_t'(d));

		// Counting and capture below trace depth
		apb_write(meter_pkg::REG_CTRL, 32'd1);
		count_en = 1'b1;
		apb_read(meter_pkg::REG_CTRL, d);
		check_data("ctrl", 32'd1, d);
		arm_capture();
		run_traffic(N_COUNT);
		verify_counts();
		verify_trace();

		// Counters frozen, trace fills up
		apb_write(meter_pkg::REG_CTRL, 32'd0);
		count_en = 1'b0;
		run_traffic(N_WRAP);
		verify_counts();
		verify_trace();

		// Full trace stays stopped
		run_traffic(N_HOLD);
		check_wptr();

		// Re-armed capture starts over at entry zero
		arm_capture();
		run_traffic(N_REARM);
		verify_trace();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
design/meter_pkg.sv
design/fml_arbiter.sv
design/fml_sram.sv
design/bus_meter.sv
design/meter_subsystem_top.sv
verification/meter_props.sv
verification/tb_meter_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the meter subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_meter_subsystem
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP" \
	-f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
	echo "Testbench reported failure, see $LOG"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
	echo "No verdict found in $LOG"
	exit 1
fi
exit 0
